// ==== hdl/pfb_pkg.sv ====
package pfb_pkg;

  // filterbank sizes
  localparam int samp_wid  = 16;               // input sample width
  localparam int coeff_wid = 16;
  localparam int fft_len   = 8;                // polyphase branches, M
  localparam int dec_fac   = 6;                // decimation, D
  localparam int ptaps     = 2;                // taps per branch
  localparam int hist_len  = ptaps * fft_len;  // history line depth
  localparam int prod_wid  = 32;               // full precision tap product
  localparam int sum_wid   = 33;               // two products plus a carry
  localparam int idx_wid   = 3;                // branch index
  localparam int frame_wid = 8;                // frame counter on tuser
  localparam int cnt_wid   = $clog2(dec_fac + 1);  // samples per frame, 0..D

  // prototype filter, entry p*M+k is tap p of branch k
  // rising then falling, a coarse window
  localparam logic signed [coeff_wid-1:0] pfb_coeffs [hist_len] = '{
    16'sd1,  16'sd2,  16'sd4,  16'sd7,  16'sd11, 16'sd15, 16'sd18, 16'sd20,  // tap 0
    16'sd20, 16'sd18, 16'sd15, 16'sd11, 16'sd7,  16'sd4,  16'sd2,  16'sd1    // tap 1
  };

  // one input sample, also one history entry
  typedef struct packed {
    logic signed [samp_wid-1:0] tdata;
  } sample_beat_t;

  // tap unit result, one branch per cycle
  typedef struct packed {
    logic                       tvalid;
    logic [idx_wid-1:0]         idx;   // branch k of this product
    logic signed [prod_wid-1:0] prod;
  } prod_beat_t;

  // output stream beat
  typedef struct packed {
    logic signed [sum_wid-1:0] tdata;  // branch sum
    logic                      tlast;  // beat M-1 of a frame
    logic [frame_wid-1:0]      tuser;  // frame index mod 256
  } out_beat_t;

  // ingest FSM
  typedef enum logic {
    st_fill,     // collecting D samples
    st_compute   // snapshot frozen, stepping k
  } ingest_state_t;

endpackage

// ==== hdl/pfb_ingest.sv ====
`timescale 1ns/10ps

module pfb_ingest (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         en,
  input  pfb_pkg::sample_beat_t        s_axis,
  input  logic                         s_axis_tvalid,
  output logic                         s_axis_tready,
  input  logic                         buf_free,             // rotator has a free half
  output pfb_pkg::sample_beat_t        hist [pfb_pkg::hist_len],
  output logic [pfb_pkg::idx_wid-1:0]  k,
  output logic                         compute,
  output logic                         event_frame_started
);
  import pfb_pkg::*;

  ingest_state_t       state;
  logic [cnt_wid-1:0]  cnt;        // samples taken in the current frame
  logic                frame_rdy;  // D samples in, waiting to compute
  logic                accept;

  assign frame_rdy = (cnt == cnt_wid'(dec_fac));

  // no new samples while a frame waits or the snapshot is in use
  assign s_axis_tready = (state == st_fill) && en && !frame_rdy;
  assign accept        = s_axis_tvalid && s_axis_tready;
  assign compute       = (state == st_compute);

  always_ff @(posedge clk) begin
    if (reset) begin
      state               <= st_fill;
      cnt                 <= '0;
      k                   <= '0;
      event_frame_started <= 1'b0;
      for (int i = 0; i < hist_len; i++) begin
        hist[i] <= '0;  // samples before the first count as zero
      end
    end else begin
      // one cycle pulse after the D-th sample of a frame
      event_frame_started <= accept && (cnt == cnt_wid'(dec_fac - 1));

      if (accept) begin
        hist[0] <= s_axis;  // newest at entry 0
        for (int i = 1; i < hist_len; i++) begin
          hist[i] <= hist[i-1];
        end
        cnt <= cnt + 1'b1;
      end

      case (state)
        st_fill: begin
          // hold off until the rotator can take a whole frame
          if (frame_rdy && buf_free) begin
            state <= st_compute;
            cnt   <= '0;
            k     <= '0;
          end
        end
        st_compute: begin
          k <= k + 1'b1;  // one branch per cycle, wraps back to 0
          if (k == idx_wid'(fft_len - 1)) begin
            state <= st_fill;
          end
        end
        default: state <= st_fill;
      endcase
    end
  end

endmodule

// ==== hdl/pfb_tap_mac.sv ====
`timescale 1ns/10ps

module pfb_tap_mac #(
  parameter int tap = 0  // 0 uses entries 0..M-1, 1 uses M..2M-1
) (
  input  logic                         clk,
  input  logic                         reset,
  input  pfb_pkg::sample_beat_t        hist [pfb_pkg::hist_len],
  input  logic [pfb_pkg::idx_wid-1:0]  k,
  input  logic                         compute,
  output pfb_pkg::prod_beat_t          prod
);
  import pfb_pkg::*;

  logic [idx_wid:0]            addr;   // history and coefficient slot
  logic signed [coeff_wid-1:0] coeff;
  logic signed [samp_wid-1:0]  samp;

  logic                        vld_q;
  logic [idx_wid-1:0]          idx_q;
  logic signed [prod_wid-1:0]  prod_q;

  // slot p*M+k, same index into both tables
  assign addr  = (idx_wid+1)'(tap * fft_len) + (idx_wid+1)'(k);
  assign coeff = pfb_coeffs[addr];
  assign samp  = hist[addr].tdata;  // x(n - p*M - k)

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= compute;  // 1 cycle behind the strobe
    end
  end

  // product and its branch tag
  always_ff @(posedge clk) begin
    idx_q  <= k;
    prod_q <= coeff * samp;  // signed 16x16 into 32
  end

  assign prod = '{
    tvalid: vld_q,
    idx:    idx_q,
    prod:   prod_q
  };

endmodule

// ==== hdl/pfb_phase_rotator.sv ====
`timescale 1ns/10ps

module pfb_phase_rotator (
  input  logic                 clk,
  input  logic                 reset,
  input  pfb_pkg::prod_beat_t  prod_a,         // tap 0 products
  input  pfb_pkg::prod_beat_t  prod_b,         // tap 1 products
  output logic                 buf_free,
  output pfb_pkg::out_beat_t   m_axis,
  output logic                 m_axis_tvalid,
  input  logic                 m_axis_tready
);
  import pfb_pkg::*;

  logic signed [sum_wid-1:0] sum_q;
  logic [idx_wid-1:0]        sum_idx;
  logic                      sum_vld;

  logic signed [sum_wid-1:0] frame_mem [2][fft_len];  // ping-pong frame store
  logic [1:0]                full;      // per half
  logic                      wr_half;   // half being filled
  logic                      rd_half;   // half being streamed
  logic [idx_wid-1:0]        rd_cnt;    // beat within frame
  logic [idx_wid-1:0]        rd_shift;  // (m*D) mod M
  logic [idx_wid-1:0]        rd_addr;
  logic [frame_wid-1:0]      frame_cnt;
  logic                      wr_done;
  logic                      rd_done;

  // add the two taps, both units run in lockstep
  always_ff @(posedge clk) begin
    if (reset) begin
      sum_vld <= 1'b0;
    end else begin
      sum_vld <= prod_a.tvalid && prod_b.tvalid;
    end
  end

  always_ff @(posedge clk) begin
    sum_q   <= sum_wid'(prod_a.prod) + sum_wid'(prod_b.prod);  // sign extended
    sum_idx <= prod_a.idx;
  end

  // branch sum lands in the filling half
  always_ff @(posedge clk) begin
    if (sum_vld) begin
      frame_mem[wr_half][sum_idx] <= sum_q;
    end
  end

  assign wr_done = sum_vld && (sum_idx == idx_wid'(fft_len - 1));
  assign rd_done = m_axis_tvalid && m_axis_tready && (rd_cnt == idx_wid'(fft_len - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      full      <= '0;
      wr_half   <= 1'b0;
      rd_half   <= 1'b0;
      rd_cnt    <= '0;
      rd_shift  <= '0;
      frame_cnt <= '0;
    end else begin
      if (wr_done) begin
        full[wr_half] <= 1'b1;  // visible on the output next cycle
        wr_half       <= !wr_half;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        rd_cnt <= rd_cnt + 1'b1;
      end
      if (rd_done) begin
        full[rd_half] <= 1'b0;
        rd_half       <= !rd_half;
        rd_shift      <= rd_shift + idx_wid'(dec_fac % fft_len);  // mod M by wrap
        frame_cnt     <= frame_cnt + 1'b1;
      end
    end
  end

  // ingest may start a frame only into an empty half
  assign buf_free = !full[wr_half];

  assign rd_addr       = rd_cnt + rd_shift;  // rotated branch
  assign m_axis_tvalid = full[rd_half];
  assign m_axis = '{
    tdata: frame_mem[rd_half][rd_addr],
    tlast: (rd_cnt == idx_wid'(fft_len - 1)),
    tuser: frame_cnt
  };

endmodule

// ==== hdl/pfb_top.sv ====
`timescale 1ns/10ps

module pfb_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   en,
  input  pfb_pkg::sample_beat_t  s_axis,
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  output pfb_pkg::out_beat_t     m_axis,
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  output logic                   event_frame_started
);
  import pfb_pkg::*;

  sample_beat_t        hist [hist_len];  // frozen during compute
  logic [idx_wid-1:0]  k;
  logic                compute;
  prod_beat_t          prod_a;
  prod_beat_t          prod_b;
  logic                buf_free;

  // sample intake and frame sequencing
  pfb_ingest u_ingest (
    .clk                 (clk),
    .reset               (reset),
    .en                  (en),
    .s_axis              (s_axis),
    .s_axis_tvalid       (s_axis_tvalid),
    .s_axis_tready       (s_axis_tready),
    .buf_free            (buf_free),
    .hist                (hist),
    .k                   (k),
    .compute             (compute),
    .event_frame_started (event_frame_started)
  );

  // tap 0, newest M samples
  pfb_tap_mac #(.tap(0)) u_tap0 (
    .clk     (clk),
    .reset   (reset),
    .hist    (hist),
    .k       (k),
    .compute (compute),
    .prod    (prod_a)
  );

  pfb_tap_mac #(.tap(1)) u_tap1 (  // older M samples
    .clk     (clk),
    .reset   (reset),
    .hist    (hist),
    .k       (k),
    .compute (compute),
    .prod    (prod_b)
  );

  pfb_phase_rotator u_rotator (
    .clk           (clk),
    .reset         (reset),
    .prod_a        (prod_a),
    .prod_b        (prod_b),
    .buf_free      (buf_free),
    .m_axis        (m_axis),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

endmodule

// ==== dv/pfb_assertions.sv ====
`timescale 1ns/10ps

module pfb_assertions (
  input logic                         clk,
  input logic                         reset,
  input pfb_pkg::out_beat_t           m_axis,
  input logic                         m_axis_tvalid,
  input logic                         m_axis_tready,
  input logic                         sum_vld,
  input logic [pfb_pkg::idx_wid-1:0]  sum_idx,
  input logic [1:0]                   full,
  input logic                         wr_half
);

  // stalled beat holds valid and payload
  a_hold: assert property (@(posedge clk) disable iff (reset)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis))
    else $error("output beat changed while stalled");

  // first branch of a frame only into an empty half
  a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
    sum_vld && (sum_idx == '0) |-> !full[wr_half])
    else $error("new frame written into a full buffer half");

  a_reset_quiet: assert property (@(posedge clk)
    reset |=> !m_axis_tvalid)  // buffer empty out of reset
    else $error("m_axis_tvalid high after reset");

endmodule

// ==== dv/pfb_tb.sv ====
`timescale 1ns/10ps

module pfb_tb;
  import pfb_pkg::*;

  localparam int clk_period  = 4;
  localparam int num_rows    = 5;
  localparam int pat_ramp    = 0;
  localparam int pat_alt     = 1;
  localparam int pat_impulse = 2;
  localparam int pat_random  = 3;

  // prototype window with tap 0 first
  localparam int ref_coeffs [16] = '{1, 2, 4, 7, 11, 15, 18, 20, 20, 18, 15, 11, 7, 4, 2, 1};

  typedef struct packed {
    logic [1:0]  pattern;
    logic [15:0] count;      // samples to send
    logic [7:0]  valid_pct;  // source valid probability
    logic [7:0]  ready_pct;  // sink ready probability
    logic        en_toggle;  // periodic en low windows
  } test_row_t;

  localparam test_row_t test_table [num_rows] = '{
    '{2'(pat_impulse), 16'd36, 8'd100, 8'd100, 1'b0},  // one spike into zero history
    '{2'(pat_ramp),    16'd48, 8'd100, 8'd100, 1'b0},  // full rate through shifts 0 6 4 2
    '{2'(pat_random),  16'd60, 8'd100, 8'd30,  1'b0},  // heavy back-pressure
    '{2'(pat_alt),     16'd42, 8'd60,  8'd100, 1'b1},  // bubbles and en low
    '{2'(pat_random),  16'd36, 8'd70,  8'd70,  1'b1}   // everything at once
  };

  logic         clk;
  logic         reset;
  logic         en;
  sample_beat_t s_axis;
  logic         s_axis_tvalid;
  logic         s_axis_tready;
  out_beat_t    m_axis;
  logic         m_axis_tvalid;
  logic         m_axis_tready;
  logic         event_frame_started;

  int   seed      = 38;
  logic signed [samp_wid-1:0] samples [$];  // every accepted input in arrival order
  int   rx_cnt    = 0;     // output beats seen
  int   ev_cnt    = 0;
  int   exp_beats = 0;
  int   errors    = 0;
  int   checks    = 0;
  logic src_took  = 1'b0;  // beat on the input went through at this edge

  pfb_top u_pfb_top (
    .clk                 (clk),
    .reset               (reset),
    .en                  (en),
    .s_axis              (s_axis),
    .s_axis_tvalid       (s_axis_tvalid),
    .s_axis_tready       (s_axis_tready),
    .m_axis              (m_axis),
    .m_axis_tvalid       (m_axis_tvalid),
    .m_axis_tready       (m_axis_tready),
    .event_frame_started (event_frame_started)
  );

  bind pfb_phase_rotator pfb_assertions u_assertions (
    .clk           (clk),
    .reset         (reset),
    .m_axis        (m_axis),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .sum_vld       (sum_vld),
    .sum_idx       (sum_idx),
    .full          (full),
    .wr_half       (wr_half)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // true with probability pct percent
  function automatic logic roll(input int pct);
    int r;
    r = $random(seed) % 100;
    if (r < 0) r += 100;
    return r < pct;
  endfunction

  function automatic logic signed [samp_wid-1:0] make_sample(input int pat, input int i);
    int v;
    case (pat)
      pat_ramp:    v = (i + 1) * 64;
      pat_alt:     v = (i % 2 == 0) ? (1000 + 13 * i) : -(1000 + 13 * i);
      pat_impulse: v = (i == 0) ? 1000 : 0;  // spike at the row start
      default:     v = $random(seed);        // full 16 bit range
    endcase
    return 16'(v);
  endfunction

  function automatic longint sample_at(input int i);
    if (i < 0) return 0;  // before the first sample
    return longint'(samples[i]);
  endfunction

  // y_k = h[k] x(n-k) + h[M+k] x(n-M-k)
  // n is the newest sample of frame m
  function automatic logic signed [sum_wid-1:0] branch_out(input int m, input int br);
    int     n;
    longint acc;
    n   = (m + 1) * dec_fac - 1;
    acc = longint'(ref_coeffs[br]) * sample_at(n - br)
        + longint'(ref_coeffs[fft_len + br]) * sample_at(n - fft_len - br);
    return sum_wid'(acc);
  endfunction

  task automatic check_beat();
    int   m;
    int   j;
    int   br;
    logic signed [sum_wid-1:0] exp_data;
    logic [frame_wid-1:0]      exp_user;
    logic                      exp_last;
    m = rx_cnt / fft_len;
    j = rx_cnt % fft_len;
    if ((m + 1) * dec_fac > samples.size()) begin
      errors++;
      $display("output frame %0d came out before its input samples were accepted", m);
    end else begin
      br       = (j + (m * dec_fac) % fft_len) % fft_len;  // rotated by s_m
      exp_data = branch_out(m, br);
      exp_last = (j == fft_len - 1);
      exp_user = frame_wid'(m);
      checks  += 3;
      if (m_axis.tdata !== exp_data) begin
        errors++;
        $display("ERR m_axis.tdata beat %0d: exp=%h act=%h", rx_cnt, exp_data, m_axis.tdata);
      end
      if (m_axis.tlast !== exp_last) begin
        errors++;
        $display("ERR m_axis.tlast beat %0d: exp=%h act=%h", rx_cnt, exp_last, m_axis.tlast);
      end
      if (m_axis.tuser !== exp_user) begin
        errors++;
        $display("ERR m_axis.tuser beat %0d: exp=%h act=%h", rx_cnt, exp_user, m_axis.tuser);
      end
    end
    rx_cnt++;
  endtask

  // handshakes and events seen mid cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (event_frame_started) ev_cnt++;
      if (m_axis_tvalid && m_axis_tready) check_beat();
      if (!en) begin
        checks++;
        if (s_axis_tready !== 1'b0) begin  // en low blocks the input
          errors++;
          $display("ERR s_axis_tready with en low: exp=%h act=%h", 1'b0, s_axis_tready);
        end
      end
    end
  end

  task automatic run_row(input int r);
    test_row_t row;
    int        sent;
    int        cyc;
    row  = test_table[r];
    sent = 0;
    cyc  = 0;
    while (sent < int'(row.count)) begin
      @(posedge clk);
      cyc++;
      m_axis_tready <= roll(int'(row.ready_pct));
      if (row.en_toggle) en <= !((cyc % 24) >= 8 && (cyc % 24) < 14);
      else en <= 1'b1;
      if (!s_axis_tvalid || src_took) begin  // otherwise hold the stalled beat
        if (roll(int'(row.valid_pct))) begin
          s_axis.tdata  <= make_sample(int'(row.pattern), sent);
          s_axis_tvalid <= 1'b1;
        end else begin
          s_axis_tvalid <= 1'b0;
        end
      end
      @(negedge clk);
      src_took = s_axis_tvalid && s_axis_tready;
      if (src_took) begin
        samples.push_back(s_axis.tdata);
        sent++;
      end
    end
  endtask

  initial begin
    reset         = 1'b1;
    en            = 1'b0;
    s_axis        = '0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    @(posedge clk);
    s_axis_tvalid <= 1'b0;  // last beat goes through on this edge
    en            <= 1'b1;
    m_axis_tready <= 1'b1;
    exp_beats = (samples.size() / dec_fac) * fft_len;
    while (rx_cnt < exp_beats) begin
      @(posedge clk);
    end
    repeat (40) @(posedge clk);  // catch stray beats
    checks += 2;
    if (rx_cnt != exp_beats) begin
      errors++;
      $display("got %0d output beats but only %0d were expected", rx_cnt, exp_beats);
    end
    if (ev_cnt != samples.size() / dec_fac) begin
      errors++;
      $display("ERR event_frame_started count: exp=%h act=%h", samples.size() / dec_fac, ev_cnt);
    end
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // 20 cycles per table sample plus slack
  initial begin
    int total;
    total = 0;
    for (int r = 0; r < num_rows; r++) begin
      total += int'(test_table[r].count);
    end
    #(20 * total * clk_period + 2000);
    $display("watchdog timeout, only %0d output beats arrived", rx_cnt);
    $display("checks=%0d errors=%0d", checks, errors);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
hdl/pfb_pkg.sv
hdl/pfb_ingest.sv
hdl/pfb_tap_mac.sv
hdl/pfb_phase_rotator.sv
hdl/pfb_top.sv
dv/pfb_assertions.sv
dv/pfb_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= pfb_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
